//--- Makefile
TOP = tb_bimc_master

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module $(TOP) -Mdir obj_dir -f sources.f

run: compile
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf obj_dir

//--- hdl/bimc_deframer.sv
// deframer for the returning chain traffic
// strobes every complete frame and flags frames cut short by an early sync
`timescale 1ns/1ps

module bimc_deframer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_idat,
  input  logic                  i_isync,
  output bimc_pkg::bimc_frame_t o_frame,
  output logic                  o_resp,
  output logic                  o_stb,
  output logic                  o_short
);

  logic [bimc_pkg::FRAME_BITS-1:0] shift_q;
  logic [bimc_pkg::SLOT_W-1:0]     bit_cnt_q;  // data bits taken since the last sync
  logic                            resp_q;
  logic                            take;

  // bits past a full frame are ignored until the next sync
  assign take = !i_isync && (bit_cnt_q != bimc_pkg::DATA_SLOTS);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt_q <= bimc_pkg::DATA_SLOTS;  // no frame in progress out of reset
      o_stb     <= 1'b0;
      o_short   <= 1'b0;
    end else begin
      o_short <= i_isync && (bit_cnt_q != bimc_pkg::DATA_SLOTS);
      o_stb   <= take && (bit_cnt_q == bimc_pkg::DATA_SLOTS - 1'b1);
      if (i_isync) begin
        bit_cnt_q <= '0;
      end else if (take) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_isync) begin
      resp_q <= i_idat;  // flag slot
    end
    if (take) begin
      shift_q <= {shift_q[bimc_pkg::FRAME_BITS-2:0], i_idat};
    end
  end

  assign o_frame = shift_q;
  assign o_resp = resp_q;

endmodule

//--- hdl/bimc_master.sv
// chain master top level
// serializer and scheduler on the transmit side, deframer and FSM on receive
`timescale 1ns/1ps

module bimc_master (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_idat,
  input  logic                  i_isync,
  input  bimc_pkg::bimc_frame_t i_cmd,
  input  logic                  i_cmd_send,
  input  logic                  i_cmd_sent_clr,
  input  bimc_pkg::poll_cfg_t   i_poll_cfg,
  input  bimc_pkg::mon_t        i_mon_mask,
  input  logic                  i_rsp_clr,
  output logic                  o_odat,
  output logic                  o_osync,
  output logic                  o_cmd_sent,
  output bimc_pkg::rd_rsp_t     o_rsp,
  output bimc_pkg::mon_t        o_monitor,
  output bimc_pkg::err_cnt_t    o_err_cnt,
  output logic [11:0]           o_mem_count,
  output logic                  o_init_done,
  output logic                  o_ecc_error,
  output logic                  o_interrupt
);

  logic                  load;
  bimc_pkg::bimc_frame_t tx_frame;
  logic                  cmd_done;
  bimc_pkg::bimc_frame_t rx_frame;
  logic                  rx_resp;
  logic                  rx_stb;
  logic                  rx_short;
  bimc_pkg::err_evt_t    err_evt;
  bimc_pkg::mon_t        mon_set;
  logic                  rsp_cap;
  bimc_pkg::bimc_frame_t rsp_frame;

  bimc_serializer u_serializer (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_frame(tx_frame),
    .o_load (load),
    .o_odat (o_odat),
    .o_osync(o_osync)
  );

  bimc_tx_sched u_tx_sched (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_load    (load),
    .i_cmd     (i_cmd),
    .i_cmd_send(i_cmd_send),
    .i_poll_cfg(i_poll_cfg),
    .o_frame   (tx_frame),
    .o_cmd_done(cmd_done)
  );

  bimc_deframer u_deframer (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_idat (i_idat),
    .i_isync(i_isync),
    .o_frame(rx_frame),
    .o_resp (rx_resp),
    .o_stb  (rx_stb),
    .o_short(rx_short)
  );

  bimc_rx_fsm u_rx_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_frame    (rx_frame),
    .i_resp     (rx_resp),
    .i_stb      (rx_stb),
    .i_short    (rx_short),
    .o_err_evt  (err_evt),
    .o_mon_set  (mon_set),
    .o_rsp_cap  (rsp_cap),
    .o_rsp_frame(rsp_frame),
    .o_mem_count(o_mem_count),
    .o_init_done(o_init_done)
  );

  bimc_status_regs u_status_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_err_evt     (err_evt),
    .i_mon_set     (mon_set),
    .i_mon_mask    (i_mon_mask),
    .i_rsp_cap     (rsp_cap),
    .i_rsp_frame   (rsp_frame),
    .i_rsp_clr     (i_rsp_clr),
    .i_cmd_done    (cmd_done),
    .i_cmd_sent_clr(i_cmd_sent_clr),
    .o_monitor     (o_monitor),
    .o_err_cnt     (o_err_cnt),
    .o_rsp         (o_rsp),
    .o_cmd_sent    (o_cmd_sent),
    .o_ecc_error   (o_ecc_error),
    .o_interrupt   (o_interrupt)
  );

endmodule

//--- hdl/bimc_pkg.sv
// frame layout, opcodes and status register addresses of the memory chain
// struct types shared by the transmit path, receive path and register block
package bimc_pkg;

  localparam int FRAME_BITS = 72;
  localparam int FRAME_SLOTS = 73;  // one flag slot ahead of the payload
  localparam int SLOT_W = $clog2(FRAME_SLOTS);
  localparam int TIMER_W = 26;
  localparam int CNT_W = 32;

  // number of data slots, also the index of the flag slot in a down count
  localparam logic [SLOT_W-1:0] DATA_SLOTS = SLOT_W'(FRAME_BITS);

  localparam logic [7:0] OP_NOP = 8'h00;
  localparam logic [7:0] OP_RD_REG = 8'h01;
  localparam logic [7:0] OP_WR_ID = 8'h02;
  localparam logic [7:0] OP_POLL_ERR = 8'h03;

  localparam logic [3:0] BCAST_TYPE = 4'hF;
  localparam logic [11:0] BCAST_MEM = 12'hFFF;
  localparam logic [15:0] ID_ADDR = 16'h0001;
  localparam logic [15:0] ECC_STAT_ADDR = 16'h0ECC;
  localparam logic [15:0] PAR_STAT_ADDR = 16'h09A4;

  typedef struct packed {
    logic [3:0]  mem_type;
    logic [7:0]  opcode;
    logic [11:0] mem;
    logic [15:0] addr;
    logic [31:0] data;
  } bimc_frame_t;

  typedef struct packed {
    logic               poll_en;
    logic [TIMER_W-1:0] poll_period;  // cycles between error polls
  } poll_cfg_t;

  typedef struct packed {
    logic uncorr_ecc;
    logic corr_ecc;
    logic parity;
    logic chain_err;
    logic bad_opcode;
    logic unanswered_rd;
  } mon_t;

  typedef struct packed {
    logic uncorr;
    logic corr;
    logic parity;
  } err_evt_t;

  typedef struct packed {
    logic [CNT_W-1:0] uncorr;
    logic [CNT_W-1:0] corr;
    logic [CNT_W-1:0] parity;
  } err_cnt_t;

  typedef struct packed {
    logic        valid;
    bimc_frame_t frame;
  } rd_rsp_t;

endpackage

//--- hdl/bimc_rx_fsm.sv
// receive FSM: sorts returning frames into command, read and poll traffic
// counts the memories and raises error events and monitor flag pulses
`timescale 1ns/1ps

module bimc_rx_fsm (
  input  logic                  clk,
  input  logic                  rst_n,
  input  bimc_pkg::bimc_frame_t i_frame,
  input  logic                  i_resp,
  input  logic                  i_stb,
  input  logic                  i_short,
  output bimc_pkg::err_evt_t    o_err_evt,
  output bimc_pkg::mon_t        o_mon_set,
  output logic                  o_rsp_cap,
  output bimc_pkg::bimc_frame_t o_rsp_frame,
  output logic [11:0]           o_mem_count,
  output logic                  o_init_done
);

  typedef enum logic [1:0] {RX_IDLE, RX_READ_WAIT, RX_POLL_WAIT} rx_state_t;

  rx_state_t          state_q;
  rx_state_t          state_d;
  bimc_pkg::err_evt_t evt_d;
  bimc_pkg::mon_t     set_d;
  logic               cap_d;
  logic               id_hit;

  always_comb begin
    state_d = state_q;
    evt_d = '0;
    set_d = '0;
    cap_d = 1'b0;
    id_hit = 1'b0;
    if (i_short) begin
      set_d.chain_err = 1'b1;  // partial frame, resync on the next one
      state_d = RX_IDLE;
    end else if (i_stb) begin
      case (state_q)
        RX_IDLE: begin
          if (!i_resp) begin
            // the ID broadcast comes back with the count added by each memory
            id_hit = (i_frame.opcode == bimc_pkg::OP_WR_ID) &&
                     (i_frame.addr == bimc_pkg::ID_ADDR);
            set_d.unanswered_rd = (i_frame.opcode == bimc_pkg::OP_RD_REG);
          end else if (i_frame.opcode == bimc_pkg::OP_RD_REG) begin
            state_d = RX_READ_WAIT;
          end else if (i_frame.opcode == bimc_pkg::OP_POLL_ERR) begin
            state_d = RX_POLL_WAIT;
          end else begin
            set_d.bad_opcode = 1'b1;
          end
        end
        RX_READ_WAIT: begin
          cap_d = i_resp && (i_frame.opcode != bimc_pkg::OP_NOP);
          state_d = RX_IDLE;
        end
        RX_POLL_WAIT: begin
          if (i_resp && (i_frame.opcode == bimc_pkg::OP_POLL_ERR)) begin
            if (i_frame.addr == bimc_pkg::ECC_STAT_ADDR) begin
              evt_d.corr = (i_frame.data[1:0] == 2'b11);
              evt_d.uncorr = i_frame.data[2] && i_frame.data[0];
            end else if (i_frame.addr == bimc_pkg::PAR_STAT_ADDR) begin
              evt_d.parity = |i_frame.data;
            end
          end
          state_d = RX_IDLE;
        end
        default: state_d = RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RX_IDLE;
      o_err_evt   <= '0;
      o_mon_set   <= '0;
      o_rsp_cap   <= 1'b0;
      o_mem_count <= '0;
      o_init_done <= 1'b0;
    end else begin
      state_q   <= state_d;
      o_err_evt <= evt_d;
      o_mon_set <= set_d;
      o_rsp_cap <= cap_d;
      if (id_hit) begin
        o_mem_count <= i_frame.data[11:0] - 1'b1;  // the master itself added one
        o_init_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cap_d) begin
      o_rsp_frame <= i_frame;
    end
  end

endmodule

//--- hdl/bimc_serializer.sv
// frame serializer for the outgoing chain
// shifts one frame per 73 slots, flag slot first and then payload msb first
`timescale 1ns/1ps

module bimc_serializer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  bimc_pkg::bimc_frame_t i_frame,
  output logic                  o_load,
  output logic                  o_odat,
  output logic                  o_osync
);

  logic [bimc_pkg::SLOT_W-1:0] slot_q;  // counts down, 0 is the last data slot
  bimc_pkg::bimc_frame_t       frame_q;

  assign o_load = (slot_q == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_q  <= '0;  // first cycle out of reset fetches a frame
      o_odat  <= 1'b0;
      o_osync <= 1'b0;
    end else begin
      o_osync <= o_load;
      if (o_load) begin
        slot_q <= bimc_pkg::DATA_SLOTS;
        o_odat <= 1'b0;  // the master only ever sends command flags
      end else begin
        slot_q <= slot_q - 1'b1;
        o_odat <= frame_q[slot_q - 1'b1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (o_load) begin
      frame_q <= i_frame;
    end
  end

endmodule

//--- hdl/bimc_status_regs.sv
// status registers: sticky maskable monitor flags and saturating error counters
// also holds the read response, the command-sent flag and the interrupt outputs
`timescale 1ns/1ps

module bimc_status_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  bimc_pkg::err_evt_t    i_err_evt,
  input  bimc_pkg::mon_t        i_mon_set,
  input  bimc_pkg::mon_t        i_mon_mask,
  input  logic                  i_rsp_cap,
  input  bimc_pkg::bimc_frame_t i_rsp_frame,
  input  logic                  i_rsp_clr,
  input  logic                  i_cmd_done,
  input  logic                  i_cmd_sent_clr,
  output bimc_pkg::mon_t        o_monitor,
  output bimc_pkg::err_cnt_t    o_err_cnt,
  output bimc_pkg::rd_rsp_t     o_rsp,
  output logic                  o_cmd_sent,
  output logic                  o_ecc_error,
  output logic                  o_interrupt
);

  bimc_pkg::mon_t        mon_q;
  bimc_pkg::mon_t        set_all;
  bimc_pkg::err_cnt_t    cnt_q;
  logic                  rsp_valid_q;
  bimc_pkg::bimc_frame_t rsp_frame_q;

  // a held mask bit keeps the counter at zero, otherwise it sticks at all ones
  function automatic logic [bimc_pkg::CNT_W-1:0] cnt_next(
    input logic [bimc_pkg::CNT_W-1:0] cnt,
    input logic                       evt,
    input logic                       clr
  );
    if (clr) begin
      return '0;
    end
    if (evt && !(&cnt)) begin
      return cnt + 1'b1;
    end
    return cnt;
  endfunction

  always_comb begin
    set_all = i_mon_set;
    set_all.uncorr_ecc = i_mon_set.uncorr_ecc | i_err_evt.uncorr;
    set_all.corr_ecc = i_mon_set.corr_ecc | i_err_evt.corr;
    set_all.parity = i_mon_set.parity | i_err_evt.parity;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mon_q       <= '0;
      cnt_q       <= '0;
      rsp_valid_q <= 1'b0;
      o_cmd_sent  <= 1'b0;
      o_ecc_error <= 1'b0;
      o_interrupt <= 1'b0;
    end else begin
      mon_q        <= (mon_q | set_all) & ~i_mon_mask;
      cnt_q.uncorr <= cnt_next(cnt_q.uncorr, i_err_evt.uncorr, i_mon_mask.uncorr_ecc);
      cnt_q.corr   <= cnt_next(cnt_q.corr, i_err_evt.corr, i_mon_mask.corr_ecc);
      cnt_q.parity <= cnt_next(cnt_q.parity, i_err_evt.parity, i_mon_mask.parity);
      o_ecc_error  <= mon_q.uncorr_ecc | mon_q.corr_ecc | mon_q.parity;
      o_interrupt  <= |mon_q;
      if (i_cmd_sent_clr) begin
        o_cmd_sent <= 1'b0;
      end else if (i_cmd_done) begin
        o_cmd_sent <= 1'b1;
      end
      if (i_rsp_clr) begin
        rsp_valid_q <= 1'b0;
      end else if (i_rsp_cap) begin
        rsp_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_rsp_cap && !rsp_valid_q) begin
      rsp_frame_q <= i_rsp_frame;  // later responses drop while one is held
    end
  end

  assign o_monitor = mon_q;
  assign o_err_cnt = cnt_q;
  assign o_rsp.valid = rsp_valid_q;
  assign o_rsp.frame = rsp_frame_q;

endmodule

//--- hdl/bimc_tx_sched.sv
// transmit scheduler: ID broadcast after reset, host commands, timed error polls
// picks the next frame whenever the serializer asks for one
`timescale 1ns/1ps

module bimc_tx_sched (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_load,
  input  bimc_pkg::bimc_frame_t i_cmd,
  input  logic                  i_cmd_send,
  input  bimc_pkg::poll_cfg_t   i_poll_cfg,
  output bimc_pkg::bimc_frame_t o_frame,
  output logic                  o_cmd_done
);

  typedef enum logic [2:0] {TX_INIT, TX_ID, TX_CMD, TX_POLL, TX_NOP} tx_state_t;

  tx_state_t                      state_q;  // kind of frame currently on the chain
  tx_state_t                      sel;
  bimc_pkg::bimc_frame_t          cmd_q;
  logic                           cmd_send_q;
  logic                           cmd_rise;
  logic                           cmd_pend_q;
  logic                           poll_pend_q;
  logic                           poll_expire;
  logic [bimc_pkg::TIMER_W-1:0]   poll_tmr_q;

  assign cmd_rise = i_cmd_send && !cmd_send_q;
  assign poll_expire = i_poll_cfg.poll_en && (poll_tmr_q == i_poll_cfg.poll_period);

  // host commands win over polls, and the ID broadcast goes before anything
  always_comb begin
    if (state_q == TX_INIT) begin
      sel = TX_ID;
    end else if (cmd_pend_q) begin
      sel = TX_CMD;
    end else if (poll_pend_q) begin
      sel = TX_POLL;
    end else begin
      sel = TX_NOP;
    end
  end

  always_comb begin
    o_frame = '0;
    o_frame.opcode = bimc_pkg::OP_NOP;
    case (sel)
      TX_ID: begin  // memories number themselves from data 1 upward
        o_frame.mem_type = bimc_pkg::BCAST_TYPE;
        o_frame.opcode = bimc_pkg::OP_WR_ID;
        o_frame.mem = bimc_pkg::BCAST_MEM;
        o_frame.addr = bimc_pkg::ID_ADDR;
        o_frame.data = 32'd1;
      end
      TX_CMD: o_frame = cmd_q;
      TX_POLL: begin
        o_frame.mem_type = bimc_pkg::BCAST_TYPE;
        o_frame.opcode = bimc_pkg::OP_POLL_ERR;
        o_frame.mem = bimc_pkg::BCAST_MEM;
        o_frame.addr = 16'hFFFF;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= TX_INIT;
      cmd_send_q  <= 1'b0;
      cmd_pend_q  <= 1'b0;
      poll_pend_q <= 1'b0;
      poll_tmr_q  <= '0;
      o_cmd_done  <= 1'b0;
    end else begin
      cmd_send_q <= i_cmd_send;
      o_cmd_done <= i_load && (sel == TX_CMD);
      if (i_load) begin
        state_q <= sel;
      end
      // an event stays pending until the slot that serves it is loaded
      cmd_pend_q  <= cmd_rise || (cmd_pend_q && !(i_load && (sel == TX_CMD)));
      poll_pend_q <= poll_expire || (poll_pend_q && !(i_load && (sel == TX_POLL)));
      if (!i_poll_cfg.poll_en || poll_expire) begin
        poll_tmr_q <= '0;
      end else begin
        poll_tmr_q <= poll_tmr_q + 1'b1;
      end
    end
  end

  // a new command replaces one that has not gone out yet
  always_ff @(posedge clk) begin
    if (cmd_rise) begin
      cmd_q <= i_cmd;
    end
  end

endmodule

//--- sources.f
hdl/bimc_pkg.sv
hdl/bimc_serializer.sv
hdl/bimc_tx_sched.sv
hdl/bimc_deframer.sv
hdl/bimc_rx_fsm.sv
hdl/bimc_status_regs.sv
hdl/bimc_master.sv
tb/tb_chain_model.sv
tb/tb_bimc_master.sv

//--- tb/tb_bimc_master.sv
// testbench for the chain master with a behavioral memory chain
// covers reset, ID count, reads, ECC polls, masking and chain faults
`timescale 1ns/1ps

module tb_bimc_master;

  localparam int NUM_MEMS = 3;
  localparam int FRAME_NS = bimc_pkg::FRAME_SLOTS * 40;
  // init, three reads, two poll phases, mask test and fault tests
  localparam int TEST_FRAMES = 5 + 3 * 6 + 2 * 14 + 16 + 14;

  logic                  clk;
  logic                  rst_n;
  logic                  idat;
  logic                  isync;
  bimc_pkg::bimc_frame_t cmd;
  logic                  cmd_send;
  logic                  cmd_sent_clr;
  bimc_pkg::poll_cfg_t   poll_cfg;
  bimc_pkg::mon_t        mon_mask;
  logic                  rsp_clr;
  logic                  odat;
  logic                  osync;
  logic                  cmd_sent;
  bimc_pkg::rd_rsp_t     rsp;
  bimc_pkg::mon_t        monitor;
  bimc_pkg::err_cnt_t    err_cnt;
  logic [11:0]           mem_count;
  logic                  init_done;
  logic                  ecc_error;
  logic                  interrupt;
  logic                  no_answer;
  logic                  cut_short;
  logic                  no_answer_used;
  logic                  short_used;
  logic                  cnt_check;
  logic [31:0]           poll_status;
  logic [31:0]           unc_polls;
  logic [31:0]           cor_polls;
  logic [31:0]           exp_rsp_data;
  logic [31:0]           seed;
  logic [31:0]           base;
  int                    errors = 0;
  int                    reads = 0;

  bimc_master u_bimc_master (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_idat        (idat),
    .i_isync       (isync),
    .i_cmd         (cmd),
    .i_cmd_send    (cmd_send),
    .i_cmd_sent_clr(cmd_sent_clr),
    .i_poll_cfg    (poll_cfg),
    .i_mon_mask    (mon_mask),
    .i_rsp_clr     (rsp_clr),
    .o_odat        (odat),
    .o_osync       (osync),
    .o_cmd_sent    (cmd_sent),
    .o_rsp         (rsp),
    .o_monitor     (monitor),
    .o_err_cnt     (err_cnt),
    .o_mem_count   (mem_count),
    .o_init_done   (init_done),
    .o_ecc_error   (ecc_error),
    .o_interrupt   (interrupt)
  );

  tb_chain_model #(.NUM_MEMS(NUM_MEMS)) u_chain (
    .clk          (clk),
    .i_odat       (odat),
    .i_osync      (osync),
    .i_no_answer  (no_answer),
    .i_cut_short  (cut_short),
    .i_poll_status(poll_status),
    .o_idat       (idat),
    .o_isync      (isync),
    .o_unc_polls  (unc_polls),
    .o_cor_polls  (cor_polls)
  );

  task automatic report_fail(input string msg);
    errors++;
    $display("Fail %0t: %s", $time, msg);
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_frames(input int n);
    repeat (n) @(posedge osync);
  endtask

  task automatic send_read();
    step();
    seed = lcg_next(seed);
    cmd = '0;
    cmd.opcode = bimc_pkg::OP_RD_REG;
    cmd.mem = 12'h001;
    cmd.addr = seed[31:16];
    seed = lcg_next(seed);
    cmd.data = seed;
    exp_rsp_data = {16'h0000, cmd.addr} ^ 32'hA5A5_0000;
    cmd_send = 1'b1;
    step();
    cmd_send = 1'b0;
  endtask

  reset_state: assert property (@(negedge clk) !rst_n |-> !odat && !osync && !interrupt &&
      !ecc_error && !cmd_sent && !rsp.valid && !init_done && err_cnt == '0)
    else report_fail("outputs not idle during reset");
  mem_count_ok: assert property (@(posedge clk) disable iff (!rst_n)
      init_done |-> mem_count == 12'(NUM_MEMS))
    else report_fail("memory count differs from the chain length");
  cmd_sent_cleared: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_sent_clr |=> !cmd_sent)
    else report_fail("command-sent flag did not clear");
  rsp_content: assert property (@(posedge clk) disable iff (!rst_n)
      rsp.valid |-> rsp.frame.opcode == bimc_pkg::OP_RD_REG && rsp.frame.data == exp_rsp_data)
    else report_fail("read response opcode or data wrong");
  rsp_cleared: assert property (@(posedge clk) disable iff (!rst_n) rsp_clr |=> !rsp.valid)
    else report_fail("read response did not clear");
  cnt_bounded: assert property (@(posedge clk) disable iff (!rst_n)
      err_cnt.uncorr <= unc_polls && err_cnt.corr <= cor_polls && err_cnt.parity == '0)
    else report_fail("error counter ahead of the polls answered");
  cnt_match: assert property (@(posedge clk) disable iff (!rst_n)
      cnt_check |-> err_cnt.uncorr == unc_polls && err_cnt.corr == cor_polls)
    else report_fail("error counter differs from the polls answered");
  flag_with_cnt: assert property (@(posedge clk) disable iff (!rst_n)
      (err_cnt.uncorr == '0 || monitor.uncorr_ecc) && (err_cnt.corr == '0 || monitor.corr_ecc))
    else report_fail("error flag missing for a counted event");
  ecc_out: assert property (@(posedge clk) disable iff (!rst_n)
      (monitor.uncorr_ecc || monitor.corr_ecc || monitor.parity) |=> ecc_error)
    else report_fail("ECC error output missing");
  irq_out: assert property (@(posedge clk) disable iff (!rst_n) (|monitor) |=> interrupt)
    else report_fail("interrupt output missing");
  mask_holds: assert property (@(posedge clk) disable iff (!rst_n)
      ($past(mon_mask) & monitor) == '0 &&
      (!$past(mon_mask.uncorr_ecc) || err_cnt.uncorr == '0) &&
      (!$past(mon_mask.corr_ecc) || err_cnt.corr == '0))
    else report_fail("masked flag or counter not zero");
  flag_cause: assert property (@(posedge clk) disable iff (!rst_n)
      (!monitor.unanswered_rd || no_answer_used) && (!monitor.chain_err || short_used) &&
      !monitor.bad_opcode && !monitor.parity)
    else report_fail("monitor flag set without a cause");

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  initial begin
    #((TEST_FRAMES + 40) * FRAME_NS);
    $display("watchdog expired before the tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    cmd = '0;
    cmd_send = 1'b0;
    cmd_sent_clr = 1'b0;
    poll_cfg = '0;
    mon_mask = '0;
    rsp_clr = 1'b0;
    no_answer = 1'b0;
    cut_short = 1'b0;
    no_answer_used = 1'b0;
    short_used = 1'b0;
    cnt_check = 1'b0;
    poll_status = '0;
    exp_rsp_data = '0;
    seed = 32'ha40;
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #2 rst_n = 1'b1;
    wait (init_done);  // ID broadcast has come back around the chain

    for (int i = 0; i < 3; i++) begin
      send_read();
      wait (cmd_sent);
      step();
      cmd_sent_clr = 1'b1;
      step();
      cmd_sent_clr = 1'b0;
      wait (rsp.valid);
      reads++;
      step();
      rsp_clr = 1'b1;
      step();
      rsp_clr = 1'b0;
    end

    step();
    poll_status = 32'h5;  // uncorrectable status first, then correctable
    poll_cfg.poll_period = 26'd200;
    poll_cfg.poll_en = 1'b1;
    wait (unc_polls >= 32'd4 && ecc_error && interrupt);
    step();
    poll_status = 32'h3;
    wait (cor_polls >= 32'd4);
    step();
    poll_cfg.poll_en = 1'b0;
    wait_frames(6);
    step();
    cnt_check = 1'b1;
    step();
    cnt_check = 1'b0;

    mon_mask.uncorr_ecc = 1'b1;
    mon_mask.corr_ecc = 1'b1;
    poll_status = 32'h5;
    poll_cfg.poll_en = 1'b1;
    base = unc_polls;
    wait (unc_polls >= base + 32'd3);
    step();
    poll_cfg.poll_en = 1'b0;
    wait_frames(6);
    step();
    mon_mask = '0;
    wait (!interrupt);

    step();
    no_answer = 1'b1;
    no_answer_used = 1'b1;
    send_read();
    wait (monitor.unanswered_rd && interrupt);
    step();
    no_answer = 1'b0;
    mon_mask.unanswered_rd = 1'b1;
    wait (!interrupt);
    step();
    cut_short = 1'b1;
    short_used = 1'b1;
    wait (monitor.chain_err && interrupt);
    step();
    cut_short = 1'b0;
    wait_frames(2);

    $display("errors %0d, read responses %0d, uncorrectable polls %0d, correctable polls %0d",
             errors, reads, unc_polls, cor_polls);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- tb/tb_chain_model.sv
// behavioral chain of memories that answers the master's frames
// returns ID, read and poll traffic and can drop a read flag or cut frames short
`timescale 1ns/1ps

module tb_chain_model #(
  parameter int NUM_MEMS = 3
) (
  input  logic        clk,
  input  logic        i_odat,
  input  logic        i_osync,
  input  logic        i_no_answer,
  input  logic        i_cut_short,
  input  logic [31:0] i_poll_status,
  output logic        o_idat,
  output logic        o_isync,
  output logic [31:0] o_unc_polls,
  output logic [31:0] o_cor_polls
);

  logic [72:0]           tx_q[$];  // response flag above each frame
  logic [72:0]           tx_word;
  bimc_pkg::bimc_frame_t rx_frame;
  logic [31:0]           unc_polls = '0;
  logic [31:0]           cor_polls = '0;
  logic                  tx_cut = 1'b0;
  int                    rx_cnt = 72;
  int                    tx_pos = 73;

  assign o_unc_polls = unc_polls;
  assign o_cor_polls = cor_polls;

  task automatic answer(input bimc_pkg::bimc_frame_t f);
    bimc_pkg::bimc_frame_t r;
    r = f;
    case (f.opcode)
      bimc_pkg::OP_WR_ID: begin
        r.data = f.data + 32'(NUM_MEMS);  // every memory takes one ID
        tx_q.push_back({1'b0, r});
      end
      bimc_pkg::OP_RD_REG: begin
        tx_q.push_back({!i_no_answer, f});
        if (!i_no_answer) begin
          r.data = {16'h0000, f.addr} ^ 32'hA5A5_0000;
          tx_q.push_back({1'b1, r});
        end
      end
      bimc_pkg::OP_POLL_ERR: begin
        tx_q.push_back({1'b1, f});
        r.addr = bimc_pkg::ECC_STAT_ADDR;
        r.data = i_poll_status;
        tx_q.push_back({1'b1, r});
        if (i_poll_status == 32'h5) begin
          unc_polls++;
        end else if (i_poll_status == 32'h3) begin
          cor_polls++;
        end
      end
      default: begin
        // a queued response rides in the slot of this NOP
        if (tx_q.size() == 0) begin
          tx_q.push_back({1'b0, f});
        end
      end
    endcase
  endtask

  always @(negedge clk) begin
    if (i_osync) begin
      rx_cnt = 0;
    end else if (rx_cnt < 72) begin
      rx_frame = {rx_frame[70:0], i_odat};
      rx_cnt++;
      if (rx_cnt == 72) begin
        answer(rx_frame);
      end
    end
  end

  initial begin
    o_idat = 1'b0;
    o_isync = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      if (tx_pos >= 73 && tx_q.size() != 0) begin
        tx_word = tx_q.pop_front();
        tx_pos = 0;
        tx_cut = i_cut_short;
      end
      if (tx_pos < 73) begin
        // an early second sync leaves too few data bits on either side
        o_isync = (tx_pos == 0) || (tx_cut && tx_pos == 30);
        o_idat = tx_word[72 - tx_pos];
        tx_pos++;
      end else begin
        o_isync = 1'b0;  // idle line between frames
        o_idat = 1'b0;
      end
    end
  end

endmodule
